// ==== list.f ====
logic/exePkg.sv
logic/exeDecodeSelect.sv
logic/exeCtlLatch.sv
logic/exe2CtlLatch.sv
logic/exeStrobeDecode.sv
logic/exeStageCtl.sv
verif/exeStageTb.sv

// ==== Makefile ====
# Verilator build and run for the execute stage control block

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := exeStageTb
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/exeStageTb.sv ====
/*
 * Execute stage control testbench
 * Random decode and pipeline strobes from a fixed seed, checked each
 * falling edge against a cycle model of the selection and latch rules.
 */
`timescale 1ns/100ps
`default_nettype none

module exeStageTb;

  localparam int NUM_CYCLES = 2000;
  localparam int TIMEOUT_CYCLES = NUM_CYCLES + NUM_CYCLES / 4;
  localparam int PLA_W = $bits(exePkg::plaCtlT);
  localparam int APU_W = $bits(exePkg::apuCtlT);

  logic CB;
  logic rst;
  logic exeAdvance;
  logic exeFlush;
  logic exe2Advance;
  logic exe2Flush;
  logic oeBit;
  logic wbHold;
  logic ltchDA;
  logic ifbFull;
  exePkg::plaCtlT pla;
  exePkg::apuCtlT apu;
  exePkg::exeCtlT exeCtlOut;
  exePkg::exe2CtlT exe2CtlOut;
  exePkg::exeStrbT exeStrbOut;
  logic lwbLdUseOut;

  // Model state
  exePkg::exeCtlT expExeCtl;
  exePkg::exe2CtlT expExe2Ctl;
  logic expLwb;

  integer seed = 32'h5c22_7cdd;
  int cycleCount = 0;
  int apuPathHits = 0;
  int nativePathHits = 0;
  int holdHits = 0;
  int lwbClearHits = 0;

  exeStageCtl DUT (
    .CB            (CB),
    .rst_i         (rst),
    .exeAdvance_i  (exeAdvance),
    .exeFlush_i    (exeFlush),
    .exe2Advance_i (exe2Advance),
    .exe2Flush_i   (exe2Flush),
    .oeBit_i       (oeBit),
    .wbHold_i      (wbHold),
    .ltchDA_i      (ltchDA),
    .ifbFull_i     (ifbFull),
    .pla_i         (pla),
    .apu_i         (apu),
    .exeCtl_o      (exeCtlOut),
    .exe2Ctl_o     (exe2CtlOut),
    .exeStrb_o     (exeStrbOut),
    .lwbLdUse_o    (lwbLdUseOut)
  );

  initial
  begin
    CB = 1'b0;
    forever #2 CB = ~CB;
  end

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  // **************************************************
  // Compare tasks
  // **************************************************
  task automatic checkExeCtl(input exePkg::exeCtlT act, input exePkg::exeCtlT exp,
                             input string name);
    if (act !== exp)
      failRun($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, act, exp));
  endtask

  task automatic checkExe2Ctl(input exePkg::exe2CtlT act, input exePkg::exe2CtlT exp,
                              input string name);
    if (act !== exp)
      failRun($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, act, exp));
  endtask

  task automatic checkStrb(input exePkg::exeStrbT act, input exePkg::exeStrbT exp,
                           input string name);
    if (act !== exp)
      failRun($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, act, exp));
  endtask

  task automatic checkBit(input logic act, input logic exp, input string name);
    if (act !== exp)
      failRun($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, act, exp));
  endtask

  // **************************************************
  // Reference model
  // **************************************************
  function automatic exePkg::exeCtlT expectDecode(input exePkg::plaCtlT p,
      input exePkg::apuCtlT a, input logic oe, input logic hold, input logic flush);
    exePkg::exeCtlT d;
    logic useApuLs;
    d = '0;
    useApuLs = a.validOp && !p.apuLdSt;
    d.load = useApuLs ? a.load : p.load;
    d.store = useApuLs ? a.store : p.store;
    d.update = useApuLs ? a.update : p.update;
    d.forceAlgn = useApuLs ? a.forceAlgn : p.forceAlgn;
    d.rpWrEn = useApuLs ? a.gprWr : p.rpWrEn;
    d.apRdEn = useApuLs ? a.raEn : p.apRdEn;
    d.bpRdEn = useApuLs ? a.rbEn : p.bpRdEn;
    d.dcuOp = useApuLs ? {a.load | a.store, a.load, a.store} : p.dcuOp;
    d.apuValidOp = a.validOp;
    d.wbLdUse = a.validOp & (hold ? a.wbLdDepend | a.exeLdDepend : a.exeLdDepend);
    d.priv = a.validOp ? a.priv : p.priv;
    d.xerOvEn = a.validOp ? a.xerOvEn : (p.oeCk & oe);
    d.xerCaEn = a.validOp ? a.xerCaEn : p.xerCaEn;
    d.apuOp = a.apuOp;
    d.fpuOp = a.fpuOp;
    d.multEn = p.multEn;
    d.divEn = p.divEn;
    d.macEn = p.mac;
    d.negMac = p.negMac;
    d.macSat = p.macSat;
    d.addEn = p.addEn;
    d.cmplmntA = p.cmplmntA;
    d.admCntl = p.admCntl;
    d.eaCalc = p.eaCalc;
    if (flush)
      d = '0;
    return d;
  endfunction

  function automatic exePkg::exe2CtlT expectExe2(input exePkg::exeCtlT c);
    exePkg::exe2CtlT s;
    s.full = 1'b1;
    s.negMac = c.negMac;
    s.multEn = c.multEn;
    s.macEn = c.macEn;
    s.multHiWd = c.admCntl[3];
    s.xerOvEn = c.xerOvEn;
    s.macSat = c.macSat;
    s.signedOp = c.admCntl[2];
    s.macOrMultEn = c.multEn | c.macEn;
    return s;
  endfunction

  function automatic exePkg::exeStrbT expectStrobes(input exePkg::exeCtlT c, input logic ifb);
    exePkg::exeStrbT s;
    logic memOp;
    memOp = c.load | c.store;
    s.eaCalc = c.eaCalc | memOp;
    s.countE1 = s.eaCalc | ifb;
    s.apuFpuOp = c.apuOp | c.fpuOp;
    s.apuFpuLoad = c.load & s.apuFpuOp;
    s.apuFpuLdSt = memOp & s.apuFpuOp;
    s.apRdEn = c.apRdEn | (memOp & c.apuOp);
    s.bpRdEn = c.bpRdEn | (memOp & c.apuOp);
    return s;
  endfunction

  always @(posedge CB)
  begin
    if (rst)
    begin
      expExeCtl <= '0;
      expExe2Ctl <= '0;
      expLwb <= 1'b0;
    end
    else
    begin
      if (exeAdvance)
        expExeCtl <= expectDecode(pla, apu, oeBit, wbHold, exeFlush);
      if (exe2Advance)
        expExe2Ctl <= exe2Flush ? '0 : expectExe2(expExeCtl);
      // Late load-use flag consumed by the data latch strobe
      if (expLwb && ltchDA)
        expLwb <= 1'b0;
      else if (exeAdvance)
        expLwb <= exeFlush ? 1'b0 : (wbHold ? apu.lwbLdDepend & !ltchDA : apu.wbLdDepend);
      // Coverage of the interesting cases
      if (exeAdvance && !exeFlush && apu.validOp && !pla.apuLdSt)
        apuPathHits <= apuPathHits + 1;
      if (exeAdvance && !exeFlush && apu.validOp && pla.apuLdSt)
        nativePathHits <= nativePathHits + 1;
      if (!exeAdvance)
        holdHits <= holdHits + 1;
      if (expLwb && ltchDA)
        lwbClearHits <= lwbClearHits + 1;
    end
  end

  // **************************************************
  // Stimulus and checks
  // **************************************************
  task automatic driveRandom();
    logic [31:0] ctlBits;
    logic [31:0] plaBits;
    logic [31:0] apuBits;
    ctlBits = $random(seed);
    plaBits = $random(seed);
    apuBits = $random(seed);
    exeFlush = (ctlBits[2:0] == 3'd0);
    exeAdvance = (ctlBits[4:3] != 2'd0);
    exe2Flush = (ctlBits[7:5] == 3'd0);
    exe2Advance = (ctlBits[9:8] != 2'd0);
    oeBit = ctlBits[10];
    wbHold = ctlBits[11];
    ltchDA = ctlBits[12];
    ifbFull = ctlBits[13];
    pla = plaBits[PLA_W-1:0];
    apu = apuBits[APU_W-1:0];
  endtask

  task automatic checkOutputs();
    checkExeCtl(exeCtlOut, expExeCtl, "exeCtl_o");
    checkExe2Ctl(exe2CtlOut, expExe2Ctl, "exe2Ctl_o");
    checkStrb(exeStrbOut, expectStrobes(expExeCtl, ifbFull), "exeStrb_o");
    checkBit(lwbLdUseOut, expLwb, "lwbLdUse_o");
  endtask

  // Run limit
  always @(posedge CB)
  begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= TIMEOUT_CYCLES)
      failRun("timeout: the run went past its cycle limit");
  end

  initial
  begin
    rst = 1'b1;
    exeAdvance = 1'b0;
    exeFlush = 1'b0;
    exe2Advance = 1'b0;
    exe2Flush = 1'b0;
    oeBit = 1'b0;
    wbHold = 1'b0;
    ltchDA = 1'b0;
    ifbFull = 1'b0;
    pla = '0;
    apu = '0;
    repeat (3) @(posedge CB);
    @(negedge CB);
    rst = 1'b0;
    // All outputs inactive straight out of reset
    checkExeCtl(exeCtlOut, '0, "exeCtl_o");
    checkExe2Ctl(exe2CtlOut, '0, "exe2Ctl_o");
    checkStrb(exeStrbOut, '0, "exeStrb_o");
    checkBit(lwbLdUseOut, 1'b0, "lwbLdUse_o");
    repeat (NUM_CYCLES)
    begin
      @(negedge CB);
      checkOutputs();
      driveRandom();
    end
    @(negedge CB);
    checkOutputs();
    if (apuPathHits > 0 && nativePathHits > 0 && holdHits > 0 && lwbClearHits > 0)
    begin
      $display("SIMULATION PASSED");
      $finish;
    end
    else
      failRun("random stimulus never reached one of the required cases");
  end

endmodule

`default_nettype wire

// ==== logic/exeStageCtl.sv ====
/*
 * Execute stage control, top level
 * Decode select feeds the execute latch, which feeds the second stage
 * latch and the strobe decode.
 */
`timescale 1ns/100ps
`default_nettype none

module exeStageCtl
(
  input  wire logic           CB,
  input  wire logic           rst_i,
  input  wire logic           exeAdvance_i,
  input  wire logic           exeFlush_i,
  input  wire logic           exe2Advance_i,
  input  wire logic           exe2Flush_i,
  input  wire logic           oeBit_i,
  input  wire logic           wbHold_i,
  input  wire logic           ltchDA_i,
  input  wire logic           ifbFull_i,
  input  wire exePkg::plaCtlT pla_i,
  input  wire exePkg::apuCtlT apu_i,
  output exePkg::exeCtlT      exeCtl_o,
  output exePkg::exe2CtlT     exe2Ctl_o,
  output exePkg::exeStrbT     exeStrb_o,
  output logic                lwbLdUse_o
);

  exePkg::exeCtlT dcdCtl;
  exePkg::exeCtlT exeCtl;

  assign exeCtl_o = exeCtl;

  // **************************************************
  // Decode side
  // **************************************************
  exeDecodeSelect uDecodeSelect (
    .pla_i      (pla_i),
    .apu_i      (apu_i),
    .oeBit_i    (oeBit_i),
    .wbHold_i   (wbHold_i),
    .exeFlush_i (exeFlush_i),
    .dcdCtl_o   (dcdCtl)
  );

  exeCtlLatch uExeCtlLatch (
    .CB           (CB),
    .rst_i        (rst_i),
    .exeAdvance_i (exeAdvance_i),
    .exeFlush_i   (exeFlush_i),
    .ltchDA_i     (ltchDA_i),
    .apu_i        (apu_i),
    .wbHold_i     (wbHold_i),
    .dcdCtl_i     (dcdCtl),
    .exeCtl_o     (exeCtl),
    .lwbLdUse_o   (lwbLdUse_o)
  );

  // **************************************************
  // Downstream of the execute latch
  // **************************************************
  exe2CtlLatch uExe2CtlLatch (
    .CB            (CB),
    .rst_i         (rst_i),
    .exe2Advance_i (exe2Advance_i),
    .exe2Flush_i   (exe2Flush_i),
    .exeCtl_i      (exeCtl),
    .exe2Ctl_o     (exe2Ctl_o)
  );

  exeStrobeDecode uStrobeDecode (
    .exeCtl_i  (exeCtl),
    .ifbFull_i (ifbFull_i),
    .exeStrb_o (exeStrb_o)
  );

endmodule

`default_nettype wire

// ==== logic/exeStrobeDecode.sv ====
/*
 * Execute stage strobe decode
 * Derives the effective address and operand read strobes from the
 * latched execute controls. Purely combinational.
 */
`timescale 1ns/100ps
`default_nettype none

module exeStrobeDecode
(
  input  wire exePkg::exeCtlT exeCtl_i,
  input  wire logic           ifbFull_i,
  output exePkg::exeStrbT     exeStrb_o
);

  logic ldOrSt;
  logic apuFpuOp;
  logic eaCalc;

  assign ldOrSt = exeCtl_i.load | exeCtl_i.store;
  assign apuFpuOp = exeCtl_i.apuOp | exeCtl_i.fpuOp;

  // Any load or store needs an EA
  assign eaCalc = exeCtl_i.eaCalc | ldOrSt;

  // **************************************************
  // Address strobes
  // **************************************************
  assign exeStrb_o.eaCalc = eaCalc;

  // E1 counter also runs while the fetch buffer is full
  assign exeStrb_o.countE1 = eaCalc | ifbFull_i;

  // **************************************************
  // APU/FPU classification
  // **************************************************
  assign exeStrb_o.apuFpuOp = apuFpuOp;
  assign exeStrb_o.apuFpuLoad = exeCtl_i.load & apuFpuOp;
  assign exeStrb_o.apuFpuLdSt = ldOrSt & apuFpuOp;

  // APU load/store always reads both operand ports
  assign exeStrb_o.apRdEn = exeCtl_i.apRdEn | (ldOrSt & exeCtl_i.apuOp);
  assign exeStrb_o.bpRdEn = exeCtl_i.bpRdEn | (ldOrSt & exeCtl_i.apuOp);

endmodule

`default_nettype wire

// ==== logic/exe2CtlLatch.sv ====
/*
 * Second execute stage latch
 * Carries the multiply and MAC controls one stage further and marks
 * the stage full on every unflushed advance.
 */
`timescale 1ns/100ps
`default_nettype none

module exe2CtlLatch
(
  input  wire logic           CB,
  input  wire logic           rst_i,
  input  wire logic           exe2Advance_i,
  input  wire logic           exe2Flush_i,
  input  wire exePkg::exeCtlT exeCtl_i,
  output exePkg::exe2CtlT     exe2Ctl_o
);

  exePkg::exe2CtlT exe2Next;

  always_comb
  begin
    exe2Next.full = 1'b1;
    exe2Next.negMac = exeCtl_i.negMac;
    exe2Next.multEn = exeCtl_i.multEn;
    exe2Next.macEn = exeCtl_i.macEn;
    // High word select and signedness come from the ADM control
    exe2Next.multHiWd = exeCtl_i.admCntl[exePkg::ADM_MULT_HI_BIT];
    exe2Next.xerOvEn = exeCtl_i.xerOvEn;
    exe2Next.macSat = exeCtl_i.macSat;
    exe2Next.signedOp = exeCtl_i.admCntl[exePkg::ADM_SIGNED_BIT];
    exe2Next.macOrMultEn = exeCtl_i.multEn | exeCtl_i.macEn;
  end

  always_ff @(posedge CB)
  begin
    if (rst_i)
      exe2Ctl_o <= '0;
    else if (exe2Advance_i)
    begin
      if (exe2Flush_i)
        exe2Ctl_o <= '0;
      else
        exe2Ctl_o <= exe2Next;
    end
  end

  // Stage only fills on an advance
  exe2FullOnAdvance: assert property (
    @(posedge CB) disable iff (rst_i)
    (!exe2Ctl_o.full && !exe2Advance_i) |=> !exe2Ctl_o.full
  );

endmodule

`default_nettype wire

// ==== logic/exeCtlLatch.sv ====
/*
 * Execute stage control latch
 * Captures the selected decode when the execute stage advances and
 * keeps the late write-back load-use flag, which drops on the cycle
 * after the data latch strobe sees it set.
 */
`timescale 1ns/100ps
`default_nettype none

module exeCtlLatch
(
  input  wire logic           CB,
  input  wire logic           rst_i,
  input  wire logic           exeAdvance_i,
  input  wire logic           exeFlush_i,
  input  wire logic           ltchDA_i,
  input  wire exePkg::apuCtlT apu_i,
  input  wire logic           wbHold_i,
  input  wire exePkg::exeCtlT dcdCtl_i,
  output exePkg::exeCtlT      exeCtl_o,
  output logic                lwbLdUse_o
);

  logic lwbClear;
  logic lwbLoad;
  logic lwbNext;

  // **************************************************
  // Execute stage register
  // **************************************************
  always_ff @(posedge CB)
  begin
    if (rst_i)
      exeCtl_o <= '0;
    else if (exeAdvance_i)
      exeCtl_o <= dcdCtl_i;
  end

  // **************************************************
  // Late write-back load-use
  // **************************************************
  // Data latch strobe consumes a pending flag
  assign lwbClear = ltchDA_i & lwbLdUse_o;
  assign lwbLoad = exeAdvance_i | lwbClear;

  // Late dependency replaces the WB one while WB stalls
  assign lwbNext = wbHold_i ? (apu_i.lwbLdDepend & ~ltchDA_i) : apu_i.wbLdDepend;

  always_ff @(posedge CB)
  begin
    if (rst_i)
      lwbLdUse_o <= 1'b0;
    else if (lwbLoad)
    begin
      if (exeFlush_i | lwbClear)
        lwbLdUse_o <= 1'b0;
      else
        lwbLdUse_o <= lwbNext;
    end
  end

  // Flag never survives a data latch strobe
  lwbSelfClear: assert property (
    @(posedge CB) disable iff (rst_i)
    (lwbLdUse_o && ltchDA_i) |=> !lwbLdUse_o
  );

  // Nothing leaks out of the stage after reset
  exeCtlResetZero: assert property (
    @(posedge CB)
    rst_i |=> (exeCtl_o == '0)
  );

endmodule

`default_nettype wire

// ==== logic/exeDecodeSelect.sv ====
/*
 * Execute stage decode select
 * Picks the native or the APU decode for each group of execute controls
 * and masks the whole result to zero under an execute flush.
 */
`timescale 1ns/100ps
`default_nettype none

module exeDecodeSelect
(
  input  wire exePkg::plaCtlT pla_i,
  input  wire exePkg::apuCtlT apu_i,
  input  wire logic           oeBit_i,
  input  wire logic           wbHold_i,
  input  wire logic           exeFlush_i,
  output exePkg::exeCtlT      dcdCtl_o
);

  logic apuLdStPath;
  logic apuLdOrSt;
  logic apuWbLdUse;

  // APU supplies load/store options unless native decode claims them
  assign apuLdStPath = apu_i.validOp & ~pla_i.apuLdSt;
  assign apuLdOrSt = apu_i.load | apu_i.store;

  // Load-use against write-back or its held copy while WB stalls
  assign apuWbLdUse = apu_i.exeLdDepend | (apu_i.wbLdDepend & wbHold_i);

  always_comb
  begin
    dcdCtl_o = '0;
    if (!exeFlush_i)
    begin
      // **************************************************
      // Load/store options
      // **************************************************
      if (apuLdStPath)
      begin
        dcdCtl_o.load = apu_i.load;
        dcdCtl_o.store = apu_i.store;
        dcdCtl_o.update = apu_i.update;
        dcdCtl_o.forceAlgn = apu_i.forceAlgn;
        dcdCtl_o.rpWrEn = apu_i.gprWr;
        dcdCtl_o.apRdEn = apu_i.raEn;
        dcdCtl_o.bpRdEn = apu_i.rbEn;
        dcdCtl_o.dcuOp = {apuLdOrSt, apu_i.load, apu_i.store};
      end
      else
      begin
        dcdCtl_o.load = pla_i.load;
        dcdCtl_o.store = pla_i.store;
        dcdCtl_o.update = pla_i.update;
        dcdCtl_o.forceAlgn = pla_i.forceAlgn;
        dcdCtl_o.rpWrEn = pla_i.rpWrEn;
        dcdCtl_o.apRdEn = pla_i.apRdEn;
        dcdCtl_o.bpRdEn = pla_i.bpRdEn;
        dcdCtl_o.dcuOp = pla_i.dcuOp;
      end

      // Privilege and XER enables
      if (apu_i.validOp)
      begin
        dcdCtl_o.apuValidOp = 1'b1;
        dcdCtl_o.wbLdUse = apuWbLdUse;
        dcdCtl_o.priv = apu_i.priv;
        dcdCtl_o.xerOvEn = apu_i.xerOvEn;
        dcdCtl_o.xerCaEn = apu_i.xerCaEn;
      end
      else
      begin
        dcdCtl_o.priv = pla_i.priv;
        dcdCtl_o.xerOvEn = pla_i.oeCk & oeBit_i;
        dcdCtl_o.xerCaEn = pla_i.xerCaEn;
      end

      dcdCtl_o.apuOp = apu_i.apuOp;
      dcdCtl_o.fpuOp = apu_i.fpuOp;

      // Unit enables always native
      dcdCtl_o.multEn = pla_i.multEn;
      dcdCtl_o.divEn = pla_i.divEn;
      dcdCtl_o.macEn = pla_i.mac;
      dcdCtl_o.negMac = pla_i.negMac;
      dcdCtl_o.macSat = pla_i.macSat;
      dcdCtl_o.addEn = pla_i.addEn;
      dcdCtl_o.cmplmntA = pla_i.cmplmntA;
      dcdCtl_o.admCntl = pla_i.admCntl;
      dcdCtl_o.eaCalc = pla_i.eaCalc;
    end
  end

endmodule

`default_nettype wire

// ==== logic/exePkg.sv ====
/*
 * Execute stage control package
 * Field widths, field types and the packed control structs shared by
 * the decode select, the execute and second-stage latches and the
 * strobe decode of the execute stage control block.
 */
`default_nettype none

package exePkg;

  // **************************************************
  // Field widths
  // **************************************************
  // Data cache op bits {load or store, load, store}
  localparam int DCU_OP_W = 3;
  localparam int ADM_CNTL_W = 4;

  // Add/divide/multiply control bit positions
  localparam int ADM_SIGNED_BIT = 2;
  localparam int ADM_MULT_HI_BIT = 3;

  typedef logic [DCU_OP_W-1:0] dcuOpT;
  typedef logic [ADM_CNTL_W-1:0] admCntlT;

  // **************************************************
  // Native decode
  // **************************************************
  typedef struct packed {
    logic load;
    logic store;
    logic update;
    logic forceAlgn;
    logic rpWrEn;
    logic apRdEn;
    logic bpRdEn;
    dcuOpT dcuOp;
    logic priv;
    logic oeCk;
    logic xerCaEn;
    logic multEn;
    logic divEn;
    logic mac;
    logic negMac;
    logic macSat;
    logic addEn;
    logic cmplmntA;
    admCntlT admCntl;
    logic eaCalc;
    // Native side keeps load/store options for an APU op
    logic apuLdSt;
  } plaCtlT;

  // **************************************************
  // APU decode
  // **************************************************
  typedef struct packed {
    logic validOp;
    logic apuOp;
    logic fpuOp;
    logic load;
    logic store;
    logic update;
    logic gprWr;
    logic raEn;
    logic rbEn;
    logic forceAlgn;
    logic priv;
    logic xerOvEn;
    logic xerCaEn;
    logic exeLdDepend;
    logic wbLdDepend;
    logic lwbLdDepend;
  } apuCtlT;

  // **************************************************
  // Execute stage controls
  // **************************************************
  typedef struct packed {
    logic load;
    logic store;
    logic update;
    logic forceAlgn;
    logic rpWrEn;
    logic apRdEn;
    logic bpRdEn;
    dcuOpT dcuOp;
    logic apuValidOp;
    logic apuOp;
    logic fpuOp;
    logic wbLdUse;
    logic priv;
    logic xerOvEn;
    logic xerCaEn;
    logic multEn;
    logic divEn;
    logic macEn;
    logic negMac;
    logic macSat;
    logic addEn;
    logic cmplmntA;
    admCntlT admCntl;
    logic eaCalc;
  } exeCtlT;

  // Second execute stage for multiply and MAC only
  typedef struct packed {
    logic full;
    logic negMac;
    logic multEn;
    logic macEn;
    logic multHiWd;
    logic xerOvEn;
    logic macSat;
    logic signedOp;
    logic macOrMultEn;
  } exe2CtlT;

  // Strobes for the operand and address logic
  typedef struct packed {
    logic eaCalc;
    logic countE1;
    logic apuFpuOp;
    logic apuFpuLoad;
    logic apuFpuLdSt;
    logic apRdEn;
    logic bpRdEn;
  } exeStrbT;

endpackage

`default_nettype wire
